/* rtl/spi_pkg.sv */
package spi_pkg;

    localparam int NCS_DEF        = 4;
    localparam int FIFO_DEPTH_DEF = 8;

    // register byte addresses
    localparam logic [7:0] ADDR_SPMODE  = 8'h00;
    localparam logic [7:0] ADDR_SPIE    = 8'h04;
    localparam logic [7:0] ADDR_SPIM    = 8'h08;
    localparam logic [7:0] ADDR_SPCOM   = 8'h0C;
    localparam logic [7:0] ADDR_SPITF   = 8'h10;
    localparam logic [7:0] ADDR_SPIRF   = 8'h14;
    localparam logic [7:0] ADDR_CSMODE0 = 8'h20;  // one word per select from here

    typedef struct packed {
        logic        en;
        logic        loop;   // mosi fed back to the receiver
        logic [29:0] rsvd;
    } spmode_t;

    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic        ci;     // sck idle level
        logic        cp;
        logic        rev;    // lsb first
        logic [4:0]  rsvd_lo;
        logic [7:0]  pm;     // half period is pm + 1 clocks
    } csmode_t;

    localparam csmode_t CSMODE_DEF = '0;

    typedef struct packed {
        logic [1:0]  cs;
        logic [13:0] rsvd;
        logic [15:0] tranlen;  // byte count minus one
    } spcom_t;

    typedef struct packed {
        logic [27:0] rsvd;
        logic        don;    // sticky until written with one
        logic        rne;
        logic        tnf;
        logic        txe;
    } spie_t;

    // frame command handed to the engine
    typedef struct packed {
        logic [1:0]  cs;
        logic [15:0] tranlen;
        csmode_t     csmode;
    } spi_cmd_t;

    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] data;
    } reg_wr_t;

    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;  // lane 0 is the first byte on the wire
    } fifo_word_u;

endpackage

/* rtl/spi_fifo.sv */
`timescale 1ns/1ps
module spi_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                S_SYSCLK,
    input  logic                S_RESETN,
    input  logic                i_push,
    input  spi_pkg::fifo_word_u i_wdata,
    input  logic                i_pop,
    output spi_pkg::fifo_word_u o_head,
    output logic                o_full,
    output logic                o_empty
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = AW + 1;

    spi_pkg::fifo_word_u mem [DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [CW-1:0]       count;
    logic                do_push;
    logic                do_pop;

    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;  // wraps for any depth
    endfunction

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;
    assign o_full  = (count == CW'(DEPTH));
    assign o_empty = (count == '0);
    assign o_head  = mem[rd_ptr];

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (do_push) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    a_count_bound: assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        count <= CW'(DEPTH));

endmodule

/* rtl/spi_regs.sv */
`timescale 1ns/1ps
module spi_regs #(
    parameter int NCS = 4
) (
    input  logic                S_SYSCLK,
    input  logic                S_RESETN,
    input  logic                i_wen,
    input  spi_pkg::reg_wr_t    i_wr,
    input  logic                i_rden,
    input  logic [7:0]          i_araddr,
    output logic [31:0]         o_rdata,
    output logic                o_int,
    output logic                o_tx_push,
    output spi_pkg::fifo_word_u o_tx_wdata,
    input  logic                i_tx_full,
    input  logic                i_tx_empty,
    output logic                o_rx_pop,
    input  spi_pkg::fifo_word_u i_rx_head,
    input  logic                i_rx_empty,
    output logic                o_start,
    output spi_pkg::spi_cmd_t   o_cmd,
    input  logic                i_busy,
    input  logic                i_done,
    output logic                o_loop
);
    localparam int CSW = (NCS > 1) ? $clog2(NCS) : 1;

    spi_pkg::spmode_t spmode;
    spi_pkg::spie_t   spim;
    spi_pkg::spie_t   spie;
    spi_pkg::spie_t   spie_w1c;
    spi_pkg::spcom_t  spcom;
    spi_pkg::csmode_t csmode [NCS];
    logic [7:0]       wr_off;
    logic [7:0]       rd_off;
    logic             wr_cs_hit;
    logic             rd_cs_hit;
    logic [CSW-1:0]   cmd_slot;

    // word aligned slot inside the csmode window
    function automatic logic cs_slot_hit(input logic [7:0] addr, input logic [7:0] off);
        return (addr >= spi_pkg::ADDR_CSMODE0) && (off[1:0] == 2'b00) &&
               (32'(off[7:2]) < NCS);
    endfunction

    assign wr_off    = i_wr.addr - spi_pkg::ADDR_CSMODE0;
    assign rd_off    = i_araddr - spi_pkg::ADDR_CSMODE0;
    assign wr_cs_hit = cs_slot_hit(i_wr.addr, wr_off);
    assign rd_cs_hit = cs_slot_hit(i_araddr, rd_off);
    assign spie_w1c  = i_wr.data;

    assign o_tx_push  = i_wen && (i_wr.addr == spi_pkg::ADDR_SPITF);
    assign o_tx_wdata = i_wr.data;
    assign o_rx_pop   = i_rden && (i_araddr == spi_pkg::ADDR_SPIRF);  // pop in the strobe cycle
    assign o_int      = |(spie & spim);
    assign o_loop     = spmode.loop;

    assign cmd_slot      = CSW'(spcom.cs);
    assign o_cmd.cs      = spcom.cs;
    assign o_cmd.tranlen = spcom.tranlen;
    assign o_cmd.csmode  = (32'(spcom.cs) < NCS) ? csmode[cmd_slot] : spi_pkg::CSMODE_DEF;

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            spmode  <= '0;
            spim    <= '0;
            spcom   <= '0;
            spie    <= '0;
            o_start <= 1'b0;
            for (int i = 0; i < NCS; i++) begin
                csmode[i] <= spi_pkg::CSMODE_DEF;
            end
        end else begin
            o_start  <= 1'b0;
            // live flags, held low while disabled
            spie.rne <= spmode.en && !i_rx_empty;
            spie.tnf <= spmode.en && !i_tx_full;
            spie.txe <= spmode.en && i_tx_empty;
            if (i_wen) begin
                case (i_wr.addr)
                    spi_pkg::ADDR_SPMODE: spmode <= i_wr.data;
                    spi_pkg::ADDR_SPIM:   spim   <= i_wr.data;
                    spi_pkg::ADDR_SPCOM: begin
                        spcom   <= i_wr.data;
                        o_start <= spmode.en && !i_busy && !o_start;  // else dropped
                    end
                    default: begin
                        if (wr_cs_hit) begin
                            csmode[wr_off[CSW+1:2]] <= i_wr.data;
                        end
                    end
                endcase
            end
            // a new done beats a clear in the same cycle
            if (i_done) begin
                spie.don <= 1'b1;
            end else if (i_wen && (i_wr.addr == spi_pkg::ADDR_SPIE) && spie_w1c.don) begin
                spie.don <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (i_rden) begin
            case (i_araddr)
                spi_pkg::ADDR_SPMODE: o_rdata <= spmode;
                spi_pkg::ADDR_SPIE:   o_rdata <= spie;
                spi_pkg::ADDR_SPIM:   o_rdata <= spim;
                spi_pkg::ADDR_SPCOM:  o_rdata <= spcom;
                spi_pkg::ADDR_SPIRF:  o_rdata <= i_rx_empty ? '0 : i_rx_head.word;
                default:              o_rdata <= rd_cs_hit ? csmode[rd_off[CSW+1:2]] : '0;
            endcase
        end
    end

    // a start must never reach an engine that is still in a frame
    a_start_idle: assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        o_start |-> !i_busy);

endmodule

/* rtl/spi_frame_engine.sv */
`timescale 1ns/1ps
module spi_frame_engine #(
    parameter int NCS = 4
) (
    input  logic                S_SYSCLK,
    input  logic                S_RESETN,
    input  logic                i_start,
    input  spi_pkg::spi_cmd_t   i_cmd,
    input  logic                i_loop,
    output logic                o_busy,
    output logic                o_done,
    output logic                o_tx_pop,
    input  spi_pkg::fifo_word_u i_tx_head,
    input  logic                i_tx_empty,
    output logic                o_rx_push,
    output spi_pkg::fifo_word_u o_rx_wdata,
    input  logic                i_rx_full,
    output logic                o_sck,
    output logic                o_mosi,
    input  logic                i_miso,
    output logic [NCS-1:0]      o_sel
);
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SELECT,
        ST_WAIT,
        ST_SHIFT,
        ST_FLUSH,
        ST_DESELECT
    } state_t;

    state_t              state;
    spi_pkg::spi_cmd_t   cmd_q;
    logic [15:0]         byte_cnt;
    logic [7:0]          div_cnt;
    logic [3:0]          edge_cnt;
    logic [7:0]          tx_byte;
    logic [7:0]          rx_byte;
    spi_pkg::fifo_word_u rx_word;
    spi_pkg::fifo_word_u rx_merge;
    logic [1:0]          lane;
    logic [2:0]          bit_idx;
    logic                rev;
    logic                tick;
    logic                first_edge;
    logic                last_byte;
    logic                word_end;
    logic                flush_go;
    logic                din;

    // wire order to bit position in the byte
    function automatic logic [2:0] bit_pos(input logic [2:0] n, input logic r);
        return r ? n : 3'd7 - n;
    endfunction

    assign lane       = byte_cnt[1:0];
    assign bit_idx    = edge_cnt[3:1];
    assign rev        = cmd_q.csmode.rev;
    assign first_edge = !edge_cnt[0];
    assign tick       = (state == ST_SHIFT) && (div_cnt == cmd_q.csmode.pm);
    assign last_byte  = (byte_cnt == cmd_q.tranlen);
    assign word_end   = (lane == 2'd3) || last_byte;
    assign flush_go   = (state == ST_FLUSH) && (!word_end || !i_rx_full);  // rx stall
    assign o_tx_pop   = flush_go && word_end;
    assign o_rx_push  = flush_go && word_end;
    assign o_rx_wdata = rx_merge;
    assign o_busy     = (state != ST_IDLE);
    assign din        = i_loop ? o_mosi : i_miso;

    // lane 0 starts a fresh word so a short tail keeps zero upper lanes
    always_comb begin
        if (lane == 2'd0) begin
            rx_merge = '0;
        end else begin
            rx_merge = rx_word;
        end
        rx_merge.lanes[lane] = rx_byte;
    end

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            state    <= ST_IDLE;
            o_sel    <= '1;
            o_sck    <= 1'b0;
            o_mosi   <= 1'b0;
            o_done   <= 1'b0;
            byte_cnt <= '0;
            div_cnt  <= '0;
            edge_cnt <= '0;
        end else begin
            o_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        o_sck    <= i_cmd.csmode.ci;
                        byte_cnt <= '0;
                        state    <= ST_SELECT;
                    end
                end
                ST_SELECT: begin
                    for (int i = 0; i < NCS; i++) begin
                        o_sel[i] <= (32'(cmd_q.cs) != i);
                    end
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (!i_tx_empty) begin  // sck idles here on underrun
                        div_cnt  <= '0;
                        edge_cnt <= '0;
                        if (cmd_q.csmode.cp) begin
                            o_mosi <= i_tx_head.lanes[lane][bit_pos(3'd0, rev)];
                        end
                        state <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    if (tick) begin
                        div_cnt  <= '0;
                        edge_cnt <= edge_cnt + 4'd1;
                        o_sck    <= ~o_sck;
                        if (first_edge && !cmd_q.csmode.cp) begin
                            o_mosi <= tx_byte[bit_pos(bit_idx, rev)];
                        end else if (!first_edge && cmd_q.csmode.cp && (bit_idx != 3'd7)) begin
                            o_mosi <= tx_byte[bit_pos(bit_idx + 3'd1, rev)];
                        end
                        if (edge_cnt == 4'hf) begin
                            state <= ST_FLUSH;  // sck back at idle
                        end
                    end else begin
                        div_cnt <= div_cnt + 8'd1;
                    end
                end
                ST_FLUSH: begin
                    if (flush_go) begin
                        if (last_byte) begin
                            o_sel <= '1;
                            state <= ST_DESELECT;
                        end else begin
                            byte_cnt <= byte_cnt + 16'd1;
                            state    <= ST_WAIT;
                        end
                    end
                end
                ST_DESELECT: begin
                    o_done <= 1'b1;
                    o_mosi <= 1'b0;
                    state  <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if ((state == ST_IDLE) && i_start) begin
            cmd_q <= i_cmd;
        end
        if (state == ST_WAIT) begin
            tx_byte <= i_tx_head.lanes[lane];
        end
        if (tick && (first_edge == cmd_q.csmode.cp)) begin
            rx_byte[bit_pos(bit_idx, rev)] <= din;  // sample edge
        end
        if (flush_go) begin
            rx_word <= rx_merge;
        end
    end

    a_one_sel: assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        $countones(~o_sel) <= 1);

endmodule

/* rtl/spi_master_top.sv */
`timescale 1ns/1ps
module spi_master_top #(
    parameter int NCS        = spi_pkg::NCS_DEF,
    parameter int FIFO_DEPTH = spi_pkg::FIFO_DEPTH_DEF
) (
    input  logic             S_SYSCLK,
    input  logic             S_RESETN,
    input  logic             i_wen,
    input  spi_pkg::reg_wr_t i_wr,
    input  logic             i_rden,
    input  logic [7:0]       i_araddr,
    output logic [31:0]      o_rdata,
    output logic             o_int,
    output logic             o_sck,
    output logic             o_mosi,
    input  logic             i_miso,
    output logic [NCS-1:0]   o_sel
);
    logic                tx_push;
    spi_pkg::fifo_word_u tx_wdata;
    logic                tx_pop;
    spi_pkg::fifo_word_u tx_head;
    logic                tx_full;
    logic                tx_empty;
    logic                rx_push;
    spi_pkg::fifo_word_u rx_wdata;
    logic                rx_pop;
    spi_pkg::fifo_word_u rx_head;
    logic                rx_full;
    logic                rx_empty;
    logic                start;
    spi_pkg::spi_cmd_t   cmd;
    logic                busy;
    logic                done;
    logic                loop;

    spi_regs #(.NCS(NCS)) u_regs (
        .S_SYSCLK   (S_SYSCLK),
        .S_RESETN   (S_RESETN),
        .i_wen      (i_wen),
        .i_wr       (i_wr),
        .i_rden     (i_rden),
        .i_araddr   (i_araddr),
        .o_rdata    (o_rdata),
        .o_int      (o_int),
        .o_tx_push  (tx_push),
        .o_tx_wdata (tx_wdata),
        .i_tx_full  (tx_full),
        .i_tx_empty (tx_empty),
        .o_rx_pop   (rx_pop),
        .i_rx_head  (rx_head),
        .i_rx_empty (rx_empty),
        .o_start    (start),
        .o_cmd      (cmd),
        .i_busy     (busy),
        .i_done     (done),
        .o_loop     (loop)
    );

    // words written through SPITF
    spi_fifo #(.DEPTH(FIFO_DEPTH)) u_txf (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .i_push   (tx_push),
        .i_wdata  (tx_wdata),
        .i_pop    (tx_pop),
        .o_head   (tx_head),
        .o_full   (tx_full),
        .o_empty  (tx_empty)
    );

    // words drained through SPIRF
    spi_fifo #(.DEPTH(FIFO_DEPTH)) u_rxf (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .i_push   (rx_push),
        .i_wdata  (rx_wdata),
        .i_pop    (rx_pop),
        .o_head   (rx_head),
        .o_full   (rx_full),
        .o_empty  (rx_empty)
    );

    spi_frame_engine #(.NCS(NCS)) u_engine (
        .S_SYSCLK   (S_SYSCLK),
        .S_RESETN   (S_RESETN),
        .i_start    (start),
        .i_cmd      (cmd),
        .i_loop     (loop),
        .o_busy     (busy),
        .o_done     (done),
        .o_tx_pop   (tx_pop),
        .i_tx_head  (tx_head),
        .i_tx_empty (tx_empty),
        .o_rx_push  (rx_push),
        .o_rx_wdata (rx_wdata),
        .i_rx_full  (rx_full),
        .o_sck      (o_sck),
        .o_mosi     (o_mosi),
        .i_miso     (i_miso),
        .o_sel      (o_sel)
    );

endmodule

/* verif/spi_tb_util.svh */
`ifndef SPI_TB_UTIL_SVH
`define SPI_TB_UTIL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic spi_pkg::csmode_t mode_word(input logic ci, input logic cp,
                                               input logic rev, input logic [7:0] pm);
    spi_pkg::csmode_t m;
    m     = spi_pkg::CSMODE_DEF;
    m.ci  = ci;
    m.cp  = cp;
    m.rev = rev;
    m.pm  = pm;
    return m;
endfunction

// expected rx word: bytes in wire order by lane, lanes past the frame end are zero
function automatic spi_pkg::fifo_word_u ref_rx_word(input logic [7:0] bytes [16],
                                                   input int nbytes, input int widx);
    spi_pkg::fifo_word_u w;
    w = '0;
    for (int k = 0; k < 4; k++) begin
        if (4 * widx + k < nbytes) begin
            w.lanes[2'(k)] = bytes[4'(4 * widx + k)];
        end
    end
    return w;
endfunction

task automatic check_word(input string what, input spi_pkg::fifo_word_u exp,
                          input spi_pkg::fifo_word_u act);
    n_checks++;
    if (act !== exp) begin
        errors++;
        $display("[ERROR] %0s: %0s expected %08h actual %08h", cur_test, what,
                 exp.word, act.word);
    end
endtask

task automatic check_spie(input string what, input spi_pkg::spie_t exp,
                          input spi_pkg::spie_t act);
    n_checks++;
    if (act !== exp) begin
        errors++;
        $display("[ERROR] %0s: %0s expected %08h actual %08h", cur_test, what, exp, act);
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
        errors++;
        $display("[ERROR] %0s: %0s expected %b actual %b", cur_test, what, exp, act);
    end
endtask

task automatic check_count(input string what, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
        errors++;
        $display("[ERROR] %0s: %0s expected %0d actual %0d", cur_test, what, exp, act);
    end
endtask

task automatic check_sel(input string what, input logic [NCS-1:0] exp,
                         input logic [NCS-1:0] act);
    n_checks++;
    if (act !== exp) begin
        errors++;
        $display("[ERROR] %0s: %0s expected %b actual %b", cur_test, what, exp, act);
    end
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    i_wen     = 1'b1;
    i_wr.addr = addr;
    i_wr.data = data;
    @(posedge S_SYSCLK);
    #2;
    i_wen = 1'b0;
endtask

// data is registered on the strobe edge
task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    i_rden   = 1'b1;
    i_araddr = addr;
    @(posedge S_SYSCLK);
    #2;
    i_rden = 1'b0;
    data   = o_rdata;
endtask

task automatic idle(input int n);
    repeat (n) @(posedge S_SYSCLK);
    #2;
endtask

`endif

/* verif/spi_tb.sv */
`timescale 1ns/1ps
module spi_tb;
    localparam int NCS         = spi_pkg::NCS_DEF;
    localparam int TOTAL_BYTES = 46;  // all frames of the run
    localparam int MAX_DIV     = 4;   // largest pm + 1 used
    localparam int LIMIT_NS    = 2 * TOTAL_BYTES * 16 * MAX_DIV * 40 + 40000;
    localparam logic [7:0] RW_ADDRS [6] = '{spi_pkg::ADDR_SPMODE, spi_pkg::ADDR_SPIM,
                                           8'h20, 8'h24, 8'h28, 8'h2C};
    localparam logic [7:0] UNMAPPED [4] = '{8'h18, 8'h21, 8'h30, 8'hFC};

    logic             S_SYSCLK;
    logic             S_RESETN;
    logic             i_wen;
    spi_pkg::reg_wr_t i_wr;
    logic             i_rden;
    logic [7:0]       i_araddr;
    logic [31:0]      o_rdata;
    logic             o_int;
    logic             o_sck;
    logic             o_mosi;
    logic             i_miso;
    logic [NCS-1:0]   o_sel;

    int                  errors = 0;
    int                  n_checks = 0;
    int                  n_tests = 0;
    int                  n_bad = 0;
    int                  test_err0 = 0;
    string               cur_test = "init";
    logic [31:0]         rng = 32'd1034;
    logic [7:0]          tx_bytes [16];
    spi_pkg::fifo_word_u exp_q [$];
    spi_pkg::fifo_word_u act_q [$];
    // frame monitor
    int                  exp_cs = 0;
    logic                exp_ci = 1'b0;
    logic                exp_cp = 1'b0;
    logic                exp_rev = 1'b0;
    int                  exp_pm = 0;
    logic                in_frame = 1'b0;
    logic                sck_prev = 1'b0;
    int                  mon_since = 0;
    int                  mon_edges = 0;
    int                  mon_frame_edges = 0;

    `include "spi_tb_util.svh"

    spi_master_top dut0 (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .i_wen    (i_wen),
        .i_wr     (i_wr),
        .i_rden   (i_rden),
        .i_araddr (i_araddr),
        .o_rdata  (o_rdata),
        .o_int    (o_int),
        .o_sck    (o_sck),
        .o_mosi   (o_mosi),
        .i_miso   (i_miso),
        .o_sel    (o_sel)
    );

    always #20 S_SYSCLK = ~S_SYSCLK;

    // rx words in order against the reference
    always @(posedge S_SYSCLK) begin
        if ((exp_q.size() > 0) && (act_q.size() > 0)) begin
            check_word("rx word", exp_q.pop_front(), act_q.pop_front());
        end
    end

    // select pattern, sck idle level, half periods and mosi bits sampled mid cycle
    always @(negedge S_SYSCLK) begin
        int bit_n;
        int wire_pos;
        if (S_RESETN && (o_sel != '1)) begin
            if (!in_frame) begin
                in_frame  = 1'b1;
                mon_edges = 0;
                mon_since = 0;
                check_bit("sck idle at select", exp_ci, o_sck);
            end else begin
                mon_since++;
                if (o_sck != sck_prev) begin
                    if (mon_edges % 16 != 0) begin  // byte gaps are longer
                        check_count("sck half period", exp_pm + 1, mon_since);
                    end
                    if ((mon_edges % 2) != int'(exp_cp)) begin  // receiver samples here
                        bit_n    = (mon_edges % 16) / 2;
                        wire_pos = exp_rev ? bit_n : 7 - bit_n;
                        check_bit("mosi bit", tx_bytes[4'(mon_edges / 16)][wire_pos], o_mosi);
                    end
                    mon_edges++;
                    mon_since = 0;
                end
            end
            check_sel("select pattern", ~(NCS'(1) << exp_cs), o_sel);
        end else if (in_frame) begin
            in_frame        = 1'b0;
            mon_frame_edges = mon_edges;
            check_bit("sck idle at deselect", exp_ci, o_sck);
        end
        sck_prev = o_sck;
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout: the tests did not finish within %0d ns", LIMIT_NS);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = errors;
        n_tests++;
    endtask

    task automatic end_test();
        while ((exp_q.size() > 0) && (act_q.size() > 0)) begin
            @(posedge S_SYSCLK);
            #2;
        end
        if ((exp_q.size() != 0) || (act_q.size() != 0)) begin
            errors++;
            $display("%0s: number of rx words read differs from the expected", cur_test);
            exp_q.delete();
            act_q.delete();
        end
        if (errors != test_err0) begin
            n_bad++;
        end
        $display("%0s: %0s, %0d errors", cur_test, (errors == test_err0) ? "ok" : "mismatch",
                 errors - test_err0);
    endtask

    task automatic push_tx(input int nwords);
        for (int w = 0; w < nwords; w++) begin
            rng = xorshift32(rng);
            for (int k = 0; k < 4; k++) begin
                tx_bytes[4'(4 * w + k)] = rng[8 * k +: 8];
            end
            write_reg(spi_pkg::ADDR_SPITF, rng);
        end
    endtask

    task automatic wait_done();
        logic [31:0]    rd;
        spi_pkg::spie_t st;
        int             polls;
        polls = 0;
        st    = '0;
        while (!st.don && (polls < 20000)) begin
            read_reg(spi_pkg::ADDR_SPIE, rd);
            st = rd;
            polls++;
        end
        if (!st.don) begin
            errors++;
            $display("%0s: frame on select %0d never finished", cur_test, exp_cs);
        end
    endtask

    task automatic run_frame(input int cs, input spi_pkg::csmode_t mode, input int nbytes,
                             input logic late_tx);
        exp_cs  = cs;
        exp_ci  = mode.ci;
        exp_cp  = mode.cp;
        exp_rev = mode.rev;
        exp_pm  = int'(mode.pm);
        write_reg(spi_pkg::ADDR_CSMODE0 + 8'(4 * cs), mode);
        if (!late_tx) begin
            push_tx((nbytes + 3) / 4);
        end
        write_reg(spi_pkg::ADDR_SPCOM, {2'(cs), 14'd0, 16'(nbytes - 1)});
        if (late_tx) begin
            idle(20);
            check_bit("select held in underrun", 1'b0, o_sel[2'(cs)]);
            check_count("sck edges in underrun", 0, mon_edges);
            push_tx((nbytes + 3) / 4);
        end
        wait_done();
        check_count("sck edges per frame", 16 * nbytes, mon_frame_edges);
    endtask

    task automatic read_rx();
        logic [31:0] rd;
        read_reg(spi_pkg::ADDR_SPIRF, rd);
        act_q.push_back(rd);
    endtask

    task automatic read_spie(output spi_pkg::spie_t st);
        logic [31:0] rd;
        idle(2);  // live bits lag the fifo flags
        read_reg(spi_pkg::ADDR_SPIE, rd);
        st = rd;
    endtask

    task automatic drain_frame(input int nbytes);
        for (int w = 0; w < (nbytes + 3) / 4; w++) begin
            exp_q.push_back(ref_rx_word(tx_bytes, nbytes, w));
            read_rx();
        end
        write_reg(spi_pkg::ADDR_SPIE, 32'h8);
    endtask

    initial begin
        logic [31:0]    rd;
        spi_pkg::spie_t st;
        S_SYSCLK = 1'b0;
        S_RESETN = 1'b0;
        i_wen    = 1'b0;
        i_wr     = '0;
        i_rden   = 1'b0;
        i_araddr = '0;
        i_miso   = 1'b0;
        repeat (4) @(posedge S_SYSCLK);
        #2;
        S_RESETN = 1'b1;

        begin_test("reg_readback");
        check_sel("sel after reset", '1, o_sel);
        check_bit("sck after reset", 1'b0, o_sck);
        check_bit("mosi after reset", 1'b0, o_mosi);
        check_bit("int after reset", 1'b0, o_int);
        for (int a = 0; a < 12; a++) begin
            read_reg(8'(4 * a), rd);
            check_word("reset value", '0, rd);
        end
        for (int r = 0; r < 6; r++) begin
            rng = xorshift32(rng);
            write_reg(RW_ADDRS[r], rng);
            read_reg(RW_ADDRS[r], rd);
            check_word("readback", rng, rd);
        end
        for (int u = 0; u < 4; u++) begin
            read_reg(UNMAPPED[u], rd);
            check_word("unmapped read", '0, rd);
        end
        write_reg(spi_pkg::ADDR_SPMODE, 32'hC000_0000);  // enabled, loopback
        write_reg(spi_pkg::ADDR_SPIM, 32'h0);
        end_test();

        begin_test("loopback_cs0");
        write_reg(spi_pkg::ADDR_SPIM, 32'h8);
        check_bit("int before frame", 1'b0, o_int);
        run_frame(0, mode_word(1'b0, 1'b0, 1'b0, 8'd1), 8, 1'b0);
        read_spie(st);
        check_spie("status after frame", 32'hF, st);
        check_bit("int on done", 1'b1, o_int);
        drain_frame(8);
        read_spie(st);
        check_spie("status after clear", 32'h3, st);
        check_bit("int after clear", 1'b0, o_int);
        write_reg(spi_pkg::ADDR_SPIM, 32'h0);
        end_test();

        begin_test("modes_cs1_3");
        run_frame(1, mode_word(1'b1, 1'b0, 1'b0, 8'd2), 8, 1'b0);
        drain_frame(8);
        run_frame(2, mode_word(1'b0, 1'b1, 1'b1, 8'd0), 8, 1'b0);
        drain_frame(8);
        run_frame(3, mode_word(1'b1, 1'b1, 1'b1, 8'd3), 8, 1'b0);
        drain_frame(8);
        end_test();

        begin_test("partial_word");
        run_frame(0, mode_word(1'b0, 1'b1, 1'b0, 8'd1), 6, 1'b0);
        exp_q.push_back(ref_rx_word(tx_bytes, 6, 0));
        exp_q.push_back(ref_rx_word(tx_bytes, 6, 1));
        read_rx();
        read_spie(st);
        check_bit("rne after first read", 1'b1, st.rne);
        read_rx();
        read_spie(st);
        check_bit("rne after second read", 1'b0, st.rne);
        write_reg(spi_pkg::ADDR_SPIE, 32'h8);
        end_test();

        begin_test("tx_underrun");
        run_frame(2, mode_word(1'b1, 1'b0, 1'b1, 8'd1), 8, 1'b1);
        drain_frame(8);
        end_test();

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d", n_tests, n_bad,
                 n_checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+verif
rtl/spi_pkg.sv
rtl/spi_fifo.sv
rtl/spi_regs.sv
rtl/spi_frame_engine.sv
rtl/spi_master_top.sv
verif/spi_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the SPI master testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module spi_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vspi_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -Fxq "=== PASS ===" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
